// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // widths with a meaning
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [63:0]  beat_t;
    typedef logic [255:0] line_t;
    typedef logic [63:0]  order_t;
    typedef logic [26:0]  line_tag_t;
    typedef logic [2:0]   word_sel_t;
    typedef logic [1:0]   beat_idx_t;

    localparam addr_t RESET_PC         = 32'haaaaa000;
    localparam int    LINE_OFFSET_BITS = 5;
    localparam int    BEATS_PER_LINE   = 4;
    localparam int    IQ_DEPTH         = 32;

    // 128 bit queue entry with order on top
    typedef struct packed {
        order_t order;
        addr_t  pc;
        word_t  inst;
    } fetch_pkt_t;

    // line request held until resp
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        line_t wdata;
    } line_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } line_resp_t;

    typedef enum logic [1:0] {
        idle,
        read_wait,
        write_burst
    } adapter_state_t;

    typedef enum logic [1:0] {
        owner_none,
        owner_inst,
        owner_data
    } arb_owner_t;

endpackage

`default_nettype wire

// ==== source/burst_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_adapter (
    input  logic                  clk,
    input  logic                  rst,

    input  fetch_pkg::line_req_t  req_i,
    output fetch_pkg::line_resp_t resp_o,

    output fetch_pkg::addr_t      bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output fetch_pkg::beat_t      bmem_wdata_o,
    input  logic                  bmem_ready_i,
    input  logic                  bmem_rvalid_i,
    input  fetch_pkg::beat_t      bmem_rdata_i
);
    import fetch_pkg::*;

    adapter_state_t state_q;
    beat_idx_t      beat_cnt_q;
    line_t          line_q;
    logic           resp_q;
    logic           last_beat;

    assign last_beat = (beat_cnt_q == beat_idx_t'(BEATS_PER_LINE - 1));

    always_comb begin
        // requester keeps addr and wdata stable for the whole transfer
        bmem_addr_o  = req_i.addr;
        bmem_wdata_o = req_i.wdata[beat_cnt_q * $bits(beat_t) +: $bits(beat_t)];
        bmem_read_o  = 1'b0;
        bmem_write_o = 1'b0;
        if (state_q == idle) begin
            bmem_read_o = req_i.read && bmem_ready_i && !resp_q;
        end else if (state_q == write_burst) begin
            bmem_write_o = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= idle;
            beat_cnt_q <= '0;
            resp_q     <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state_q)
                idle: begin
                    // resp cycle still sees the old request
                    if (!resp_q) begin
                        beat_cnt_q <= '0;
                        if (req_i.read && bmem_ready_i) begin
                            state_q <= read_wait;
                        end else if (req_i.write) begin
                            state_q <= write_burst;
                        end
                    end
                end
                read_wait: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + beat_idx_t'(1);
                        if (last_beat) begin
                            resp_q  <= 1'b1;
                            state_q <= idle;
                        end
                    end
                end
                write_burst: begin
                    // low ready holds the current beat
                    if (bmem_ready_i) begin
                        beat_cnt_q <= beat_cnt_q + beat_idx_t'(1);
                        if (last_beat) begin
                            resp_q  <= 1'b1;
                            state_q <= idle;
                        end
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // lowest beat first
    always_ff @(posedge clk) begin
        if (state_q == read_wait && bmem_rvalid_i) begin
            line_q[beat_cnt_q * $bits(beat_t) +: $bits(beat_t)] <= bmem_rdata_i;
        end
    end

    assign resp_o.resp  = resp_q;
    assign resp_o.rdata = line_q;

endmodule

`default_nettype wire

// ==== source/line_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_arbiter (
    input  logic                  clk,
    input  logic                  rst,

    input  fetch_pkg::line_req_t  ifill_req_i,
    output fetch_pkg::line_resp_t ifill_resp_o,

    input  fetch_pkg::line_req_t  dfill_req_i,
    output fetch_pkg::line_resp_t dfill_resp_o,

    output fetch_pkg::line_req_t  mem_req_o,
    input  fetch_pkg::line_resp_t mem_resp_i
);
    import fetch_pkg::*;

    arb_owner_t owner_q;
    arb_owner_t owner;
    logic       ifill_active;
    logic       dfill_active;

    assign ifill_active = ifill_req_i.read || ifill_req_i.write;
    assign dfill_active = dfill_req_i.read || dfill_req_i.write;

    // data side wins a fresh grant
    always_comb begin
        owner = owner_q;
        if (owner_q == owner_none) begin
            if (dfill_active) begin
                owner = owner_data;
            end else if (ifill_active) begin
                owner = owner_inst;
            end
        end
    end

    always_comb begin
        case (owner)
            owner_data: mem_req_o = dfill_req_i;
            owner_inst: mem_req_o = ifill_req_i;
            default:    mem_req_o = '0;
        endcase
    end

    always_comb begin
        ifill_resp_o.rdata = mem_resp_i.rdata;
        dfill_resp_o.rdata = mem_resp_i.rdata;
        ifill_resp_o.resp  = mem_resp_i.resp && (owner == owner_inst);
        dfill_resp_o.resp  = mem_resp_i.resp && (owner == owner_data);
    end

    // held until its resp pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= owner_none;
        end else if (mem_resp_i.resp) begin
            owner_q <= owner_none;
        end else begin
            owner_q <= owner;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  redirect_i,
    input  fetch_pkg::addr_t      redirect_pc_i,

    input  logic                  iq_full_i,
    output logic                  iq_enqueue_o,
    output fetch_pkg::fetch_pkt_t iq_pkt_o,
    output logic                  iq_flush_o,

    output fetch_pkg::line_req_t  ifill_req_o,
    input  fetch_pkg::line_resp_t ifill_resp_i
);
    import fetch_pkg::*;

    addr_t     pc_q;
    order_t    order_q;

    // one line buffer
    logic      buf_valid_q;
    line_tag_t buf_tag_q;
    line_t     buf_line_q;

    logic      fill_pending_q;
    addr_t     fill_addr_q;

    line_tag_t pc_tag;
    word_sel_t pc_word;
    logic      hit;
    logic      fetch_go;
    logic      start_fill;

    assign pc_tag  = pc_q[$bits(addr_t)-1:LINE_OFFSET_BITS];
    assign pc_word = pc_q[LINE_OFFSET_BITS-1:2];
    assign hit     = buf_valid_q && (buf_tag_q == pc_tag);

    assign fetch_go   = hit && !iq_full_i && !redirect_i;
    assign start_fill = !fill_pending_q && !hit && !redirect_i;

    assign iq_enqueue_o = fetch_go;
    assign iq_flush_o   = redirect_i;

    always_comb begin
        iq_pkt_o.order = order_q;
        iq_pkt_o.pc    = pc_q;
        iq_pkt_o.inst  = buf_line_q[pc_word * $bits(word_t) +: $bits(word_t)];
    end

    // read only, line aligned
    always_comb begin
        ifill_req_o      = '0;
        ifill_req_o.read = fill_pending_q;
        ifill_req_o.addr = fill_addr_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= RESET_PC;
            order_q <= '0;
        end else if (redirect_i) begin
            // order keeps counting across flushes
            pc_q <= redirect_pc_i;
        end else if (fetch_go) begin
            pc_q    <= pc_q + addr_t'(4);
            order_q <= order_q + order_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_pending_q <= 1'b0;
            buf_valid_q    <= 1'b0;
        end else if (fill_pending_q) begin
            // an outstanding fill still lands after a redirect
            if (ifill_resp_i.resp) begin
                fill_pending_q <= 1'b0;
                buf_valid_q    <= 1'b1;
            end
        end else if (start_fill) begin
            fill_pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill_addr_q <= {pc_tag, {LINE_OFFSET_BITS{1'b0}}};
        end
        if (fill_pending_q && ifill_resp_i.resp) begin
            buf_line_q <= ifill_resp_i.rdata;
            buf_tag_q  <= fill_addr_q[$bits(addr_t)-1:LINE_OFFSET_BITS];
        end
    end

endmodule

`default_nettype wire

// ==== source/inst_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int DEPTH = fetch_pkg::IQ_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  flush_i,

    input  logic                  enqueue_i,
    input  fetch_pkg::fetch_pkt_t pkt_i,
    output logic                  full_o,

    input  logic                  dequeue_i,
    output fetch_pkg::fetch_pkt_t pkt_o,
    output logic                  empty_o
);
    import fetch_pkg::*;

    fetch_pkt_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] head_q;
    logic [$clog2(DEPTH)-1:0] tail_q;
    logic [$clog2(DEPTH):0]   count_q;
    logic                     do_enq;
    logic                     do_deq;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == ($clog2(DEPTH) + 1)'(DEPTH));

    // push when full, pop when empty are dropped
    assign do_enq = enqueue_i && !full_o && !flush_i;
    assign do_deq = dequeue_i && !empty_o && !flush_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // pointers wrap on power-of-two depth
            if (do_enq) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_deq) begin
                head_q <= head_q + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[tail_q] <= pkt_i;
        end
    end

    assign pkt_o = mem[head_q];

endmodule

`default_nettype wire

// ==== source/fetch_front_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_front_top (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  redirect_i,
    input  fetch_pkg::addr_t      redirect_pc_i,

    input  logic                  inst_dequeue_i,
    output fetch_pkg::fetch_pkt_t inst_pkt_o,
    output logic                  inst_empty_o,

    input  fetch_pkg::line_req_t  dfill_req_i,
    output fetch_pkg::line_resp_t dfill_resp_o,

    output fetch_pkg::addr_t      bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output fetch_pkg::beat_t      bmem_wdata_o,
    input  logic                  bmem_ready_i,
    input  logic                  bmem_rvalid_i,
    input  fetch_pkg::beat_t      bmem_rdata_i
);
    import fetch_pkg::*;

    line_req_t  ifill_req;
    line_resp_t ifill_resp;
    line_req_t  mem_req;
    line_resp_t mem_resp;

    logic       iq_enqueue;
    logic       iq_flush;
    logic       iq_full;
    fetch_pkt_t iq_pkt;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .iq_full_i    (iq_full),
        .iq_enqueue_o (iq_enqueue),
        .iq_pkt_o     (iq_pkt),
        .iq_flush_o   (iq_flush),
        .ifill_req_o  (ifill_req),
        .ifill_resp_i (ifill_resp)
    );

    inst_queue #(
        .DEPTH(IQ_DEPTH)
    ) u_inst_queue (
        .clk      (clk),
        .rst      (rst),
        .flush_i  (iq_flush),
        .enqueue_i(iq_enqueue),
        .pkt_i    (iq_pkt),
        .full_o   (iq_full),
        .dequeue_i(inst_dequeue_i),
        .pkt_o    (inst_pkt_o),
        .empty_o  (inst_empty_o)
    );

    line_arbiter u_line_arbiter (
        .clk         (clk),
        .rst         (rst),
        .ifill_req_i (ifill_req),
        .ifill_resp_o(ifill_resp),
        .dfill_req_i (dfill_req_i),
        .dfill_resp_o(dfill_resp_o),
        .mem_req_o   (mem_req),
        .mem_resp_i  (mem_resp)
    );

    burst_adapter u_burst_adapter (
        .clk          (clk),
        .rst          (rst),
        .req_i        (mem_req),
        .resp_o       (mem_resp),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_ready_i (bmem_ready_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .bmem_rdata_i (bmem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             gaps_i,

    input  fetch_pkg::addr_t addr_i,
    input  logic             read_i,
    input  logic             write_i,
    input  fetch_pkg::beat_t wdata_i,
    output logic             ready_o,
    output logic             rvalid_o,
    output fetch_pkg::beat_t rdata_o
);
    import fetch_pkg::*;

    // written lines by line address
    line_t     lines [addr_t];

    addr_t     rd_addr;
    int        rd_started;
    int        rd_finished;
    beat_idx_t rd_beat;
    beat_idx_t wr_beat;
    logic      gaps_q;

    function automatic line_t default_line(addr_t base);
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = (base + addr_t'(i * 4)) ^ 32'h5a5a5a5a;
        end
        return l;
    endfunction

    function automatic line_t line_at(addr_t a);
        addr_t base;
        base = {a[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        if (lines.exists(base)) begin
            return lines[base];
        end
        return default_line(base);
    endfunction

    initial begin
        ready_o  = 1'b0;
        rvalid_o = 1'b0;
        rdata_o  = '0;
    end

    // commands are taken at the rising edge
    always @(posedge clk) begin
        line_t l;
        addr_t base;
        gaps_q = gaps_i;
        if (rst) begin
            rd_started = 0;
            wr_beat    = '0;
        end else begin
            if (read_i && ready_o) begin
                rd_addr    = addr_i;
                rd_started = rd_started + 1;
            end
            if (write_i && ready_o) begin
                base = {addr_i[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
                l    = line_at(addr_i);
                l[wr_beat*64 +: 64] = wdata_i;
                lines[base] = l;
                wr_beat     = wr_beat + 2'd1;
            end
        end
    end

    // outputs change on the falling edge
    always @(negedge clk) begin
        line_t l;
        rvalid_o = 1'b0;
        if (rst) begin
            ready_o     = 1'b1;
            rd_finished = 0;
            rd_beat     = '0;
        end else begin
            // ready drops about one cycle in four
            ready_o = !gaps_q || ($urandom % 4 != 0);
            if (rd_started != rd_finished && !(gaps_q && $urandom % 3 == 0)) begin
                l        = line_at(rd_addr);
                rvalid_o = 1'b1;
                rdata_o  = l[rd_beat*64 +: 64];
                if (rd_beat == 2'd3) begin
                    rd_finished = rd_finished + 1;
                end
                rd_beat = rd_beat + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_fetch_front.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front;
    import fetch_pkg::*;

    localparam int    NUM_TESTS   = 5;
    localparam int    TEST_CYCLES = 4000;
    localparam int    WAIT_LIMIT  = 500;
    localparam addr_t DATA_ADDR   = 32'h10000040;

    logic       clk;
    logic       rst;
    logic       redirect;
    addr_t      redirect_pc;
    logic       inst_dequeue;
    fetch_pkt_t inst_pkt;
    logic       inst_empty;
    line_req_t  dfill_req;
    line_resp_t dfill_resp;
    addr_t      bmem_addr;
    logic       bmem_read;
    logic       bmem_write;
    beat_t      bmem_wdata;
    logic       bmem_ready;
    logic       bmem_rvalid;
    beat_t      bmem_rdata;
    logic       mem_gaps;
    logic       data_done;

    // next packet expected at the queue head
    addr_t      exp_pc;
    order_t     exp_order;

    fetch_front_top u_fetch_front_top (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_dequeue_i(inst_dequeue),
        .inst_pkt_o    (inst_pkt),
        .inst_empty_o  (inst_empty),
        .dfill_req_i   (dfill_req),
        .dfill_resp_o  (dfill_resp),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_write_o  (bmem_write),
        .bmem_wdata_o  (bmem_wdata),
        .bmem_ready_i  (bmem_ready),
        .bmem_rvalid_i (bmem_rvalid),
        .bmem_rdata_i  (bmem_rdata)
    );

    mem_model u_mem_model (
        .clk     (clk),
        .rst     (rst),
        .gaps_i  (mem_gaps),
        .addr_i  (bmem_addr),
        .read_i  (bmem_read),
        .write_i (bmem_write),
        .wdata_i (bmem_wdata),
        .ready_o (bmem_ready),
        .rvalid_o(bmem_rvalid),
        .rdata_o (bmem_rdata)
    );

    initial begin
        clk = 1'b1;
        forever #50 clk = ~clk;
    end

    task automatic stop_failed(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_pkt(string name, fetch_pkt_t got, fetch_pkt_t exp);
        if (got !== exp) begin
            stop_failed($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            stop_failed($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_failed($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    // check the head, then pop it at the next edge
    task automatic pop_expect();
        fetch_pkt_t exp;
        int         waited;
        waited = 0;
        while (inst_empty) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_failed("instruction queue stayed empty for too long");
            end
        end
        exp.order = exp_order;
        exp.pc    = exp_pc;
        exp.inst  = exp_pc ^ 32'h5a5a5a5a;
        check_pkt("inst_pkt_o", inst_pkt, exp);
        inst_dequeue = 1'b1;
        @(negedge clk);
        inst_dequeue = 1'b0;
        exp_pc    = exp_pc + 32'd4;
        exp_order = exp_order + 64'd1;
    endtask

    task automatic pop_many(int n);
        for (int i = 0; i < n; i++) begin
            pop_expect();
        end
    endtask

    task automatic wait_full();
        int waited;
        waited = 0;
        while (!u_fetch_front_top.u_inst_queue.full_o) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_failed("instruction queue never became full");
            end
        end
    endtask

    task automatic data_access(input logic is_write, input addr_t addr,
                               input line_t wdata, output line_t rdata);
        int waited;
        waited          = 0;
        dfill_req.read  = !is_write;
        dfill_req.write = is_write;
        dfill_req.addr  = addr;
        dfill_req.wdata = wdata;
        @(negedge clk);
        while (!dfill_resp.resp) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_failed("data line request got no response");
            end
        end
        rdata     = dfill_resp.rdata;
        dfill_req = '0;
        // one cycle pulse only
        @(negedge clk);
        check_bit("dfill_resp_o.resp", dfill_resp.resp, 1'b0);
    endtask

    task automatic sequential_fetch();
        mem_gaps = 1'b0;
        pop_many(40);
    endtask

    task automatic gapped_fetch();
        mem_gaps = 1'b1;
        pop_many(40);
    endtask

    task automatic queue_backpressure();
        wait_full();
        pop_many(IQ_DEPTH);
        pop_many(10);
    endtask

    task automatic redirect_flush();
        addr_t parked;
        addr_t target;
        pop_many(4);
        wait_full();
        // fetch waits on the packet after the last queued one
        parked = exp_pc + addr_t'(IQ_DEPTH * 4);
        target = {parked[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}} + 32'h114;
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect = 1'b0;
        check_bit("inst_empty_o", inst_empty, 1'b1);
        exp_order = exp_order + order_t'(IQ_DEPTH);
        exp_pc    = target;
        pop_many(20);
    endtask

    task automatic data_port_traffic();
        line_t wline;
        line_t rline;
        for (int i = 0; i < 8; i++) begin
            wline[i*32 +: 32] = {16'hd00d, 8'(i), 8'(7 - i)};
        end
        data_done = 1'b0;
        fork
            begin
                data_access(1'b1, DATA_ADDR, wline, rline);
                data_access(1'b0, DATA_ADDR, '0, rline);
                check_line("dfill_resp_o.rdata", rline, wline);
                data_done = 1'b1;
            end
            begin
                while (!data_done) begin
                    pop_expect();
                end
            end
        join
        pop_many(8);
    endtask

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
        stop_failed("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'h9125bba3));
        rst          = 1'b1;
        redirect     = 1'b0;
        redirect_pc  = '0;
        inst_dequeue = 1'b0;
        dfill_req    = '0;
        mem_gaps     = 1'b0;
        data_done    = 1'b0;
        exp_pc       = RESET_PC;
        exp_order    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_bit("bmem_read_o", bmem_read, 1'b0);
        check_bit("bmem_write_o", bmem_write, 1'b0);
        check_bit("dfill_resp_o.resp", dfill_resp.resp, 1'b0);
        check_bit("inst_empty_o", inst_empty, 1'b1);
        rst = 1'b0;

        sequential_fetch();
        gapped_fetch();
        queue_backpressure();
        redirect_flush();
        data_port_traffic();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/fetch_pkg.sv
source/burst_adapter.sv
source/line_arbiter.sv
source/fetch_unit.sv
source/inst_queue.sv
source/fetch_front_top.sv
bench/mem_model.sv
bench/tb_fetch_front.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_front
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
